// File: all.f
+incdir+verilog
verilog/dma_pkg.sv
verilog/tcp_pkg.sv
verilog/sync_fifo.sv
verilog/dma_read_issuer.sv
verilog/tcp_tx_sequencer.sv
verilog/dma_tcp_sender.sv
verification/tb_dma_tcp_sender.sv

// File: verification/tb_dma_tcp_sender.sv
`timescale 1ns/1ps
`include "txr_params.svh"

module tb_dma_tcp_sender;
	import dma_pkg::*;
	import tcp_pkg::*;

	localparam int reset_cycles = 16;
	localparam int n_tests      = 6;
	// 4 + 2 + (64 + 3 + 8) payload beats over all tests
	localparam int n_pay_beats  = 81;
	localparam int cycle_limit  = reset_cycles + 200 * n_tests + 4 * n_pay_beats;

	logic        clk;
	logic        rstn;
	dma_cfg_t    cfg;
	logic        conn_valid;
	logic        conn_ready;
	conn_req_t   conn;
	logic        ack_valid;
	logic        ack_ready;
	ack_req_t    ack;
	logic        cnt_valid;
	logic        cnt_ready;
	cnt_req_t    cnt;
	logic        cmd_valid;
	logic        cmd_ready;
	send_cmd_t   cmd;
	logic        rd_cmd_valid;
	logic        rd_cmd_ready;
	dma_rd_cmd_t rd_cmd;
	logic        rd_data_valid;
	logic        rd_data_ready;
	dma_beat_t   rd_data;
	logic        tx_meta_valid;
	logic        tx_meta_ready;
	tx_meta_t    tx_meta;
	logic        tx_data_valid;
	logic        tx_data_ready;
	tx_beat_t    tx_data;

	tx_meta_t    meta_q [$];
	tx_beat_t    beat_q [$];
	dma_rd_cmd_t rd_q [$];
	int          ready_pct;
	int          cycles;
	int          meta_errors;
	int          beat_errors;
	int          rd_errors;
	int          other_errors;

	dma_tcp_sender DUT (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	//////////////////////////////////////////////////
	// watchdog, receiver and monitors
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: expected output still missing after %0d cycles", cycle_limit);
			report_counts();
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		tx_meta_ready = 1'b0;
		tx_data_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			tx_meta_ready = rstn && ($urandom_range(99, 0) < ready_pct);
			tx_data_ready = rstn && ($urandom_range(99, 0) < ready_pct);
		end
	end

	// a handshake seen at the falling edge completes at the next rising edge
	always @(negedge clk) begin
		if (tx_meta_valid && tx_meta_ready) begin
			meta_q.push_back(tx_meta);
		end
		if (tx_data_valid && tx_data_ready) begin
			beat_q.push_back(tx_data);
		end
	end

	// DMA memory where each beat carries its own byte address
	initial begin : dma_model
		dma_rd_cmd_t req;
		int          n_beats;
		rd_cmd_ready  = 1'b0;
		rd_data_valid = 1'b0;
		rd_data       = '0;
		forever begin
			@(negedge clk);
			if (rd_cmd_valid) begin
				req = rd_cmd;
				rd_q.push_back(req);
				@(posedge clk);
				#1;
				rd_cmd_ready = 1'b1;
				@(posedge clk);
				#1;
				rd_cmd_ready = 1'b0;
				n_beats = req.length >> `TXR_BEAT_SHIFT;
				for (int i = 0; i < n_beats; i++) begin
					repeat ($urandom_range(1, 0)) begin
						@(posedge clk);
						#1;
					end
					rd_data_valid = 1'b1;
					rd_data.data  = `TXR_DATA_W'(req.addr + 64'(i) * 64);
					rd_data.keep  = '1;
					rd_data.last  = (i == n_beats - 1);
					@(negedge clk);
					while (!rd_data_ready) begin
						@(negedge clk);
					end
					@(posedge clk);
					#1;
					rd_data_valid = 1'b0;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// expected values
	//////////////////////////////////////////////////

	function automatic tx_meta_t make_meta(input logic [31:0] len, input logic [15:0] session);
		tx_meta_t m;
		m.length  = len;
		m.session = session;
		return m;
	endfunction

	// code in bits 15:0 and the message field from bit 16 up
	function automatic tx_beat_t make_frame(input logic [15:0] code, input logic [95:0] field);
		tx_beat_t b;
		b.data         = '0;
		b.data[15:0]   = code;
		b.data[111:16] = field;
		b.keep         = '1;
		b.last         = 1'b1;
		return b;
	endfunction

	function automatic tx_beat_t make_pay_beat(input logic [63:0] addr, input int idx,
			input int n);
		tx_beat_t b;
		b.data = `TXR_DATA_W'(addr + 64'(idx) * 64);
		b.keep = '1;
		b.last = (idx == n - 1);
		return b;
	endfunction

	function automatic send_cmd_t make_cmd(input logic [4:0] buf_id, input logic [15:0] session,
			input logic [31:0] offset, input logic [31:0] len);
		send_cmd_t c;
		c.buf_id  = buf_id;
		c.session = session;
		c.offset  = offset;
		c.length  = len;
		return c;
	endfunction

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_meta(input string name, input tx_meta_t exp, input tx_meta_t act);
		if (act !== exp) begin
			meta_errors++;
			$display("Fail %s: tx_meta expected length %0d session %h, actual length %0d session %h",
				name, exp.length, exp.session, act.length, act.session);
		end
	endtask

	task automatic check_beat(input string name, input tx_beat_t exp, input tx_beat_t act);
		if (act !== exp) begin
			beat_errors++;
			$display("Fail %s: tx_data expected data %h keep %h last %b, actual data %h keep %h last %b",
				name, exp.data, exp.keep, exp.last, act.data, act.keep, act.last);
		end
	endtask

	task automatic check_rd_cmd(input string name, input dma_rd_cmd_t exp,
			input dma_rd_cmd_t act);
		if (act !== exp) begin
			rd_errors++;
			$display("Fail %s: rd_cmd expected addr %h length %0d, actual addr %h length %0d",
				name, exp.addr, exp.length, act.addr, act.length);
		end
	endtask

	task automatic report_counts();
		$display("errors: meta %0d, data %0d, read command %0d, other %0d",
			meta_errors, beat_errors, rd_errors, other_errors);
	endtask

	//////////////////////////////////////////////////
	// request drivers start just after a rising edge
	//////////////////////////////////////////////////

	task automatic send_conn(input logic [15:0] session);
		conn_valid   = 1'b1;
		conn.session = session;
		@(negedge clk);
		while (!conn_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		conn_valid = 1'b0;
	endtask

	task automatic send_ack(input logic [15:0] session, input logic accept);
		ack_valid   = 1'b1;
		ack.session = session;
		ack.accept  = accept;
		@(negedge clk);
		while (!ack_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		ack_valid = 1'b0;
	endtask

	task automatic send_cnt(input logic [15:0] session, input logic [63:0] count);
		cnt_valid   = 1'b1;
		cnt.session = session;
		cnt.count   = count;
		@(negedge clk);
		while (!cnt_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		cnt_valid = 1'b0;
	endtask

	task automatic send_cmd(input send_cmd_t c);
		cmd_valid = 1'b1;
		cmd       = c;
		@(negedge clk);
		while (!cmd_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// response collection
	//////////////////////////////////////////////////

	task automatic wait_outputs(input int n_meta, input int n_beat, input int n_rd);
		@(posedge clk);
		while (meta_q.size() < n_meta || beat_q.size() < n_beat || rd_q.size() < n_rd) begin
			@(posedge clk);
		end
		#1;
	endtask

	task automatic expect_ctrl_msg(input string name, input tx_meta_t meta, input tx_beat_t frame);
		tx_meta_t m;
		tx_beat_t b;
		m = meta_q.pop_front();
		b = beat_q.pop_front();
		check_meta(name, meta, m);
		check_beat(name, frame, b);
	endtask

	task automatic expect_command(input string name, input send_cmd_t c);
		dma_rd_cmd_t exp_rd;
		dma_rd_cmd_t got_rd;
		tx_meta_t    m;
		tx_beat_t    b;
		int          n;
		// info area first, then one window per buffer
		exp_rd.addr   = cfg.dma_base + 64'(cfg.info_len);
		exp_rd.addr   = exp_rd.addr + 64'(c.buf_id) * 64'(cfg.session_len) + 64'(c.offset);
		exp_rd.length = c.length;
		got_rd = rd_q.pop_front();
		check_rd_cmd(name, exp_rd, got_rd);
		expect_ctrl_msg(name, make_meta(`TXR_CTRL_LEN, c.session),
			make_frame(`TXR_CODE_CTRL, 96'(c.length)));
		m = meta_q.pop_front();
		check_meta(name, make_meta(c.length, c.session), m);
		n = c.length / 64;
		for (int i = 0; i < n; i++) begin
			b = beat_q.pop_front();
			check_beat(name, make_pay_beat(exp_rd.addr, i, n), b);
		end
	endtask

	task automatic settle(input string name);
		repeat (20) @(posedge clk);
		#1;
		if (meta_q.size() != 0 || beat_q.size() != 0 || rd_q.size() != 0) begin
			other_errors++;
			$display("%s: unexpected extra output, %0d metadata, %0d data beats, %0d reads left",
				name, meta_q.size(), beat_q.size(), rd_q.size());
		end
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_conn();
		send_conn(16'h0a11);
		wait_outputs(1, 1, 0);
		expect_ctrl_msg("conn", make_meta(`TXR_CTRL_LEN, 16'h0a11), make_frame(16'd0, '0));
		settle("conn");
	endtask

	task automatic test_ack();
		send_ack(16'h0b22, 1'b1);
		send_ack(16'h0b23, 1'b0);
		wait_outputs(2, 2, 0);
		expect_ctrl_msg("ack", make_meta(`TXR_CTRL_LEN, 16'h0b22),
			make_frame(`TXR_CODE_ACK, 96'd1));
		expect_ctrl_msg("ack", make_meta(`TXR_CTRL_LEN, 16'h0b23),
			make_frame(`TXR_CODE_ACK, 96'd0));
		settle("ack");
	endtask

	task automatic test_cnt();
		send_cnt(16'h0c33, 64'h0123_4567_89ab_cdef);
		wait_outputs(1, 1, 0);
		expect_ctrl_msg("cnt", make_meta(`TXR_CTRL_LEN, 16'h0c33),
			make_frame(`TXR_CODE_CNT, 96'(64'h0123_4567_89ab_cdef)));
		settle("cnt");
	endtask

	task automatic test_command();
		send_cmd_t c;
		c = make_cmd(5'd3, 16'h0d44, 32'h200, 32'd256);
		send_cmd(c);
		wait_outputs(2, 5, 1);
		expect_command("command", c);
		settle("command");
	endtask

	task automatic test_priority();
		send_cmd_t c;
		c = make_cmd(5'd7, 16'h0e58, 32'h1c0, 32'd128);
		fork
			send_conn(16'h0e55);
			send_ack(16'h0e56, 1'b1);
			send_cnt(16'h0e57, 64'd9000);
			send_cmd(c);
		join
		wait_outputs(5, 6, 1);
		expect_ctrl_msg("priority", make_meta(`TXR_CTRL_LEN, 16'h0e55), make_frame(16'd0, '0));
		expect_ctrl_msg("priority", make_meta(`TXR_CTRL_LEN, 16'h0e56),
			make_frame(`TXR_CODE_ACK, 96'd1));
		expect_ctrl_msg("priority", make_meta(`TXR_CTRL_LEN, 16'h0e57),
			make_frame(`TXR_CODE_CNT, 96'd9000));
		expect_command("priority", c);
		settle("priority");
	endtask

	// long first payload so the payload FIFO fills
	task automatic test_backpressure();
		send_cmd_t c0;
		send_cmd_t c1;
		send_cmd_t c2;
		c0 = make_cmd(5'd1, 16'h0f01, 32'h0, 32'd4096);
		c2 = make_cmd(5'd31, 16'h0f03, 32'h40, 32'd512);
		c1 = make_cmd(5'd12, 16'h0f02, 32'h3000, 32'd192);
		ready_pct = 25;
		send_cmd(c0);
		send_cmd(c1);
		send_cmd(c2);
		wait_outputs(6, 78, 3);
		expect_command("backpressure", c0);
		expect_command("backpressure", c1);
		expect_command("backpressure", c2);
		ready_pct = 50;
		settle("backpressure");
	endtask

	initial begin
		void'($urandom(48));
		cycles           = 0;
		meta_errors      = 0;
		beat_errors      = 0;
		rd_errors        = 0;
		other_errors     = 0;
		ready_pct        = 50;
		rstn             = 1'b0;
		cfg.dma_base     = 64'h0000_0010_0000_0000;
		cfg.info_len     = 32'h0000_1000;
		cfg.session_len  = 32'h0001_0000;
		conn_valid       = 1'b0;
		conn             = '0;
		ack_valid        = 1'b0;
		ack              = '0;
		cnt_valid        = 1'b0;
		cnt              = '0;
		cmd_valid        = 1'b0;
		cmd              = '0;
		repeat (reset_cycles) @(posedge clk);
		#1;
		rstn = 1'b1;
		@(posedge clk);
		#1;
		test_conn();
		test_ack();
		test_cnt();
		test_command();
		test_priority();
		test_backpressure();
		report_counts();
		if (meta_errors + beat_errors + rd_errors + other_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: verilog/dma_pkg.sv
`include "txr_params.svh"

package dma_pkg;

	// session window layout in host memory
	typedef struct packed {
		logic [63:0] dma_base;
		logic [31:0] info_len;
		logic [31:0] session_len;
	} dma_cfg_t;

	typedef struct packed {
		logic [63:0] addr;
		logic [31:0] length;
	} dma_rd_cmd_t;

	typedef struct packed {
		logic [`TXR_DATA_W-1:0] data;
		logic [`TXR_KEEP_W-1:0] keep;
		logic                   last;
	} dma_beat_t;

	// one payload fetch, handed over by the sequencer
	typedef struct packed {
		logic [`TXR_BUF_W-1:0] buf_id;
		logic [31:0]           offset;
		logic [31:0]           length;
	} dma_job_t;

endpackage

// File: verilog/dma_read_issuer.sv
`timescale 1ns/1ps
`include "txr_params.svh"

module dma_read_issuer (
	input  logic                 clk,
	input  logic                 rstn,
	input  dma_pkg::dma_cfg_t    cfg,
	input  logic                 job_valid,
	input  dma_pkg::dma_job_t    job,
	output logic                 rd_cmd_valid,
	input  logic                 rd_cmd_ready,
	output dma_pkg::dma_rd_cmd_t rd_cmd,
	input  logic                 rd_data_valid,
	output logic                 rd_data_ready,
	input  dma_pkg::dma_beat_t   rd_data,
	output logic                 pay_push,
	output dma_pkg::dma_beat_t   pay_beat,
	input  logic                 pay_almost_full
);
	import dma_pkg::*;

	typedef enum logic [1:0] {
		iss_idle,
		iss_cmd,
		iss_data
	} iss_state_e;

	iss_state_e  state;
	dma_rd_cmd_t next_cmd;
	logic [63:0] session_base;
	logic [31:0] beat_cnt;
	logic [31:0] last_idx;
	logic        beat_take;
	logic        beat_last;

	//////////////////////////////////////////////////
	// address of the requested slice
	//////////////////////////////////////////////////

	always_comb begin
		session_base = cfg.dma_base + 64'(cfg.info_len)
			+ 64'(job.buf_id) * 64'(cfg.session_len);
		next_cmd.addr   = session_base + 64'(job.offset);
		next_cmd.length = job.length;
	end

	// command and beat count captured on the job strobe
	always_ff @(posedge clk) begin
		if (state == iss_idle && job_valid) begin
			rd_cmd   <= next_cmd;
			last_idx <= (job.length >> `TXR_BEAT_SHIFT) - 32'd1;
		end
	end

	//////////////////////////////////////////////////
	// command issue and beat counting
	//////////////////////////////////////////////////

	assign rd_cmd_valid  = (state == iss_cmd);
	assign rd_data_ready = (state == iss_data) && !pay_almost_full;
	assign beat_take     = rd_data_valid && rd_data_ready;
	assign beat_last     = (beat_cnt == last_idx);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state    <= iss_idle;
			beat_cnt <= '0;
		end else begin
			case (state)
				iss_idle: begin
					if (job_valid) begin
						state    <= iss_cmd;
						beat_cnt <= '0;
					end
				end
				iss_cmd: begin
					if (rd_cmd_ready) begin
						state <= iss_data;
					end
				end
				iss_data: begin
					if (beat_take && beat_last) begin
						state <= iss_idle;
					end else if (beat_take) begin
						beat_cnt <= beat_cnt + 32'd1;
					end
				end
				default: state <= iss_idle;
			endcase
		end
	end

	// last comes from our own count, not from the DMA side
	assign pay_push      = beat_take;
	assign pay_beat.data = rd_data.data;
	assign pay_beat.keep = rd_data.keep;
	assign pay_beat.last = beat_last;

	assert property (@(posedge clk) disable iff (!rstn)
		rd_cmd_valid && !rd_cmd_ready |=> rd_cmd_valid && $stable(rd_cmd))
		else $error("dma_read_issuer: rd_cmd changed before acceptance");

	// sequencer only hands over a job once the previous payload drained
	assert property (@(posedge clk) disable iff (!rstn) job_valid |-> state == iss_idle)
		else $error("dma_read_issuer: job arrived while busy");

endmodule

// File: verilog/dma_tcp_sender.sv
`timescale 1ns/1ps
`include "txr_params.svh"

module dma_tcp_sender (
	input  logic                 clk,
	input  logic                 rstn,
	input  dma_pkg::dma_cfg_t    cfg,
	input  logic                 conn_valid,
	output logic                 conn_ready,
	input  tcp_pkg::conn_req_t   conn,
	input  logic                 ack_valid,
	output logic                 ack_ready,
	input  tcp_pkg::ack_req_t    ack,
	input  logic                 cnt_valid,
	output logic                 cnt_ready,
	input  tcp_pkg::cnt_req_t    cnt,
	input  logic                 cmd_valid,
	output logic                 cmd_ready,
	input  tcp_pkg::send_cmd_t   cmd,
	output logic                 rd_cmd_valid,
	input  logic                 rd_cmd_ready,
	output dma_pkg::dma_rd_cmd_t rd_cmd,
	input  logic                 rd_data_valid,
	output logic                 rd_data_ready,
	input  dma_pkg::dma_beat_t   rd_data,
	output logic                 tx_meta_valid,
	input  logic                 tx_meta_ready,
	output tcp_pkg::tx_meta_t    tx_meta,
	output logic                 tx_data_valid,
	input  logic                 tx_data_ready,
	output tcp_pkg::tx_beat_t    tx_data
);
	import dma_pkg::*;

	logic      job_valid;
	dma_job_t  job;
	logic      pay_push;
	dma_beat_t pay_in;
	logic      pay_af;
	logic      pay_pop;
	dma_beat_t pay_out;
	logic      pay_empty;

	tcp_tx_sequencer u_seq (
		.clk           (clk),
		.rstn          (rstn),
		.conn_valid    (conn_valid),
		.conn_ready    (conn_ready),
		.conn          (conn),
		.ack_valid     (ack_valid),
		.ack_ready     (ack_ready),
		.ack           (ack),
		.cnt_valid     (cnt_valid),
		.cnt_ready     (cnt_ready),
		.cnt           (cnt),
		.cmd_valid     (cmd_valid),
		.cmd_ready     (cmd_ready),
		.cmd           (cmd),
		.job_valid     (job_valid),
		.job           (job),
		.pay_empty     (pay_empty),
		.pay_beat      (pay_out),
		.pay_pop       (pay_pop),
		.tx_meta_valid (tx_meta_valid),
		.tx_meta_ready (tx_meta_ready),
		.tx_meta       (tx_meta),
		.tx_data_valid (tx_data_valid),
		.tx_data_ready (tx_data_ready),
		.tx_data       (tx_data)
	);

	dma_read_issuer u_issuer (
		.clk             (clk),
		.rstn            (rstn),
		.cfg             (cfg),
		.job_valid       (job_valid),
		.job             (job),
		.rd_cmd_valid    (rd_cmd_valid),
		.rd_cmd_ready    (rd_cmd_ready),
		.rd_cmd          (rd_cmd),
		.rd_data_valid   (rd_data_valid),
		.rd_data_ready   (rd_data_ready),
		.rd_data         (rd_data),
		.pay_push        (pay_push),
		.pay_beat        (pay_in),
		.pay_almost_full (pay_af)
	);

	// payload queue between DMA and TCP
	sync_fifo #(
		.width      ($bits(dma_beat_t)),
		.depth_bits (`TXR_PAY_DEPTH_BITS)
	) u_pay_fifo (
		.clk         (clk),
		.rstn        (rstn),
		.push        (pay_push),
		.din         (pay_in),
		.almost_full (pay_af),
		.pop         (pay_pop),
		.dout        (pay_out),
		.empty       (pay_empty)
	);

endmodule

// File: verilog/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter int width      = $bits(dma_pkg::dma_beat_t),
	parameter int depth_bits = 5
) (
	input  logic             clk,
	input  logic             rstn,
	input  logic             push,
	input  logic [width-1:0] din,
	output logic             almost_full,
	input  logic             pop,
	output logic [width-1:0] dout,
	output logic             empty
);
	localparam int depth = 1 << depth_bits;

	logic [width-1:0]      mem [depth];
	logic [depth_bits-1:0] wr_ptr;
	logic [depth_bits-1:0] rd_ptr;
	logic [depth_bits:0]   count;
	logic                  full;
	logic                  do_push;
	logic                  do_pop;

	assign full        = (count == (depth_bits+1)'(depth));
	assign empty       = (count == '0);
	// two slots of slack for registered producers
	assign almost_full = (count >= (depth_bits+1)'(depth - 2));
	assign do_push     = push && !full;
	assign do_pop      = pop && !empty;

	// show-ahead, head entry always visible
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// callers must respect almost_full and empty
	assert property (@(posedge clk) disable iff (!rstn) !(push && full) && !(pop && empty))
		else $error("sync_fifo: push while full or pop while empty");

endmodule

// File: verilog/tcp_pkg.sv
`include "txr_params.svh"

package tcp_pkg;

	typedef struct packed {
		logic [`TXR_SESSION_W-1:0] session;
	} conn_req_t;

	typedef struct packed {
		logic [`TXR_SESSION_W-1:0] session;
		logic                      accept;
	} ack_req_t;

	typedef struct packed {
		logic [`TXR_SESSION_W-1:0] session;
		logic [63:0]               count;
	} cnt_req_t;

	// host command, 85 bits
	typedef struct packed {
		logic [`TXR_BUF_W-1:0]     buf_id;
		logic [`TXR_SESSION_W-1:0] session;
		logic [31:0]               offset;
		logic [31:0]               length;
	} send_cmd_t;

	typedef struct packed {
		logic [31:0]               length;
		logic [`TXR_SESSION_W-1:0] session;
	} tx_meta_t;

	typedef struct packed {
		logic [`TXR_DATA_W-1:0] data;
		logic [`TXR_KEEP_W-1:0] keep;
		logic                   last;
	} tx_beat_t;

	typedef enum logic [1:0] {
		frame_conn,
		frame_ack,
		frame_cnt,
		frame_ctrl
	} frame_kind_e;

	typedef enum logic [2:0] {
		st_idle,
		st_pop,
		st_meta,
		st_frame,
		st_pay_meta,
		st_payload
	} seq_state_e;

endpackage

// File: verilog/tcp_tx_sequencer.sv
`timescale 1ns/1ps
`include "txr_params.svh"

module tcp_tx_sequencer (
	input  logic               clk,
	input  logic               rstn,
	input  logic               conn_valid,
	output logic               conn_ready,
	input  tcp_pkg::conn_req_t conn,
	input  logic               ack_valid,
	output logic               ack_ready,
	input  tcp_pkg::ack_req_t  ack,
	input  logic               cnt_valid,
	output logic               cnt_ready,
	input  tcp_pkg::cnt_req_t  cnt,
	input  logic               cmd_valid,
	output logic               cmd_ready,
	input  tcp_pkg::send_cmd_t cmd,
	output logic               job_valid,
	output dma_pkg::dma_job_t  job,
	input  logic               pay_empty,
	input  dma_pkg::dma_beat_t pay_beat,
	output logic               pay_pop,
	output logic               tx_meta_valid,
	input  logic               tx_meta_ready,
	output tcp_pkg::tx_meta_t  tx_meta,
	output logic               tx_data_valid,
	input  logic               tx_data_ready,
	output tcp_pkg::tx_beat_t  tx_data
);
	import tcp_pkg::*;

	seq_state_e                state;
	frame_kind_e               kind;
	logic                      conn_pend;
	logic                      ack_pend;
	logic                      cnt_pend;
	conn_req_t                 conn_q;
	ack_req_t                  ack_q;
	cnt_req_t                  cnt_q;
	logic                      cmd_push;
	logic                      cmd_pop;
	logic                      cmd_af;
	logic                      cmd_empty;
	send_cmd_t                 cmd_head;
	logic [`TXR_SESSION_W-1:0] cur_session;
	logic [31:0]               cur_len;
	logic [`TXR_DATA_W-1:0]    frame_data;
	logic                      meta_take;
	logic                      data_take;
	logic                      frame_done;

	//////////////////////////////////////////////////
	// request latches and command queue
	//////////////////////////////////////////////////

	assign conn_ready = !conn_pend;
	assign ack_ready  = !ack_pend;
	assign cnt_ready  = !cnt_pend;
	assign cmd_ready  = !cmd_af;
	assign cmd_push   = cmd_valid && cmd_ready;
	assign cmd_pop    = (state == st_pop);

	always_ff @(posedge clk) begin
		if (conn_valid && conn_ready) begin
			conn_q <= conn;
		end
		if (ack_valid && ack_ready) begin
			ack_q <= ack;
		end
		if (cnt_valid && cnt_ready) begin
			cnt_q <= cnt;
		end
	end

	sync_fifo #(
		.width      ($bits(send_cmd_t)),
		.depth_bits (`TXR_CMD_DEPTH_BITS)
	) u_cmd_fifo (
		.clk         (clk),
		.rstn        (rstn),
		.push        (cmd_push),
		.din         (cmd),
		.almost_full (cmd_af),
		.pop         (cmd_pop),
		.dout        (cmd_head),
		.empty       (cmd_empty)
	);

	//////////////////////////////////////////////////
	// main FSM
	//////////////////////////////////////////////////

	assign meta_take  = tx_meta_valid && tx_meta_ready;
	assign data_take  = tx_data_valid && tx_data_ready;
	assign frame_done = (state == st_frame) && data_take;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state     <= st_idle;
			kind      <= frame_conn;
			conn_pend <= 1'b0;
			ack_pend  <= 1'b0;
			cnt_pend  <= 1'b0;
			job_valid <= 1'b0;
		end else begin
			job_valid <= 1'b0;
			// a request stays pending until its frame beat is sent
			if (conn_valid && conn_ready) begin
				conn_pend <= 1'b1;
			end else if (frame_done && kind == frame_conn) begin
				conn_pend <= 1'b0;
			end
			if (ack_valid && ack_ready) begin
				ack_pend <= 1'b1;
			end else if (frame_done && kind == frame_ack) begin
				ack_pend <= 1'b0;
			end
			if (cnt_valid && cnt_ready) begin
				cnt_pend <= 1'b1;
			end else if (frame_done && kind == frame_cnt) begin
				cnt_pend <= 1'b0;
			end

			case (state)
				st_idle: begin
					if (conn_pend) begin
						kind  <= frame_conn;
						state <= st_meta;
					end else if (ack_pend) begin
						kind  <= frame_ack;
						state <= st_meta;
					end else if (cnt_pend) begin
						kind  <= frame_cnt;
						state <= st_meta;
					end else if (!cmd_empty) begin
						state <= st_pop;
					end
				end
				st_pop: begin
					kind      <= frame_ctrl;
					job_valid <= 1'b1;
					state     <= st_meta;
				end
				st_meta: begin
					if (meta_take) begin
						state <= st_frame;
					end
				end
				st_frame: begin
					if (data_take) begin
						state <= (kind == frame_ctrl) ? st_pay_meta : st_idle;
					end
				end
				st_pay_meta: begin
					if (meta_take) begin
						state <= st_payload;
					end
				end
				st_payload: begin
					if (pay_pop && pay_beat.last) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// working copy of the message being sent
	always_ff @(posedge clk) begin
		if (state == st_idle) begin
			if (conn_pend) begin
				cur_session <= conn_q.session;
			end else if (ack_pend) begin
				cur_session <= ack_q.session;
			end else if (cnt_pend) begin
				cur_session <= cnt_q.session;
			end
		end
		if (state == st_pop) begin
			cur_session <= cmd_head.session;
			cur_len     <= cmd_head.length;
			job.buf_id  <= cmd_head.buf_id;
			job.offset  <= cmd_head.offset;
			job.length  <= cmd_head.length;
		end
	end

	//////////////////////////////////////////////////
	// frame build and TCP outputs
	//////////////////////////////////////////////////

	always_comb begin
		frame_data = '0;
		case (kind)
			frame_conn: frame_data = '0;
			frame_ack: begin
				frame_data[15:0] = `TXR_CODE_ACK;
				frame_data[16]   = ack_q.accept;
			end
			frame_cnt: begin
				frame_data[15:0]  = `TXR_CODE_CNT;
				frame_data[79:16] = cnt_q.count;
			end
			frame_ctrl: begin
				frame_data[15:0]  = `TXR_CODE_CTRL;
				frame_data[47:16] = cur_len;
			end
			default: frame_data = '0;
		endcase
	end

	always_comb begin
		tx_meta_valid   = (state == st_meta) || (state == st_pay_meta);
		tx_meta.length  = (state == st_pay_meta) ? cur_len : 32'(`TXR_CTRL_LEN);
		tx_meta.session = cur_session;
		tx_data_valid   = 1'b0;
		tx_data.data    = frame_data;
		tx_data.keep    = '1;
		tx_data.last    = 1'b1;
		pay_pop         = 1'b0;
		case (state)
			st_frame: tx_data_valid = 1'b1;
			st_payload: begin
				tx_data_valid = !pay_empty;
				tx_data.data  = pay_beat.data;
				tx_data.keep  = pay_beat.keep;
				tx_data.last  = pay_beat.last;
				pay_pop       = !pay_empty && tx_data_ready;
			end
			default: tx_data_valid = 1'b0;
		endcase
	end

	assert property (@(posedge clk) disable iff (!rstn) !(tx_meta_valid && tx_data_valid))
		else $error("tcp_tx_sequencer: metadata and data offered together");

endmodule

// File: verilog/txr_params.svh
`ifndef TXR_PARAMS_SVH
`define TXR_PARAMS_SVH

// beat geometry
`define TXR_DATA_W          512
`define TXR_KEEP_W          64
`define TXR_BEAT_SHIFT      6

// identifiers
`define TXR_SESSION_W       16
`define TXR_BUF_W           5

// queue depths, as address bits
`define TXR_CMD_DEPTH_BITS  4
`define TXR_PAY_DEPTH_BITS  5

// control frame, always a single full beat
`define TXR_CTRL_LEN        64

// frame codes in the low 16 bits
`define TXR_CODE_ACK        16'd1
`define TXR_CODE_CNT        16'd2
`define TXR_CODE_CTRL       16'd3

`endif
